// ==== verilog/ramp_pkg.sv ====
`default_nettype none

package ramp_pkg;

	// shared speed-ramp table
	localparam int RAMP_ADDR_W = 6;                 // 64 entries
	localparam int RAMP_DATA_W = 16;                // period, slot ticks per step
	localparam int RAMP_DEPTH  = 2 ** RAMP_ADDR_W;

	// slot ring, must cover every axis and the
	// two cycles of address register plus ram read
	localparam int N_SLOTS = 8;

endpackage

`default_nettype wire

// ==== verilog/axis_pkg.sv ====
`default_nettype none

package axis_pkg;

	localparam int N_AXES = 2;      // number of axis controllers
	localparam int STEP_W = 16;     // step count, position and stroke
	localparam int CMD_W  = 2;

	typedef enum logic [CMD_W-1:0] {
		CMD_MOVE = 2'd0,    // ramped move of i_step steps
		CMD_HOME = 2'd1,    // seek home sensor, negative direction
		CMD_STOP = 2'd2     // abort at next tick
	} axis_cmd_e;

	typedef enum logic [1:0] {
		ST_IDLE     = 2'd0,
		ST_RUN      = 2'd1,
		ST_HOMING   = 2'd2,
		ST_ACK_WAIT = 2'd3  // motion over, ack still up
	} axis_state_e;

endpackage

`default_nettype wire

// ==== verilog/ramp_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ramp_port_if import ramp_pkg::*; ();

	logic                   tick;       // one cycle in this axis's slot
	logic [RAMP_ADDR_W-1:0] acc_addr;
	logic [RAMP_ADDR_W-1:0] dec_addr;
	logic [RAMP_DATA_W-1:0] acc_data;   // valid at the tick
	logic [RAMP_DATA_W-1:0] dec_data;
	logic [RAMP_ADDR_W-1:0] addr_max;   // last table address written

	modport sched (
		output tick,
		output acc_data,
		output dec_data,
		output addr_max,
		input  acc_addr,
		input  dec_addr
	);

	modport axis (
		input  tick,
		input  acc_data,
		input  dec_data,
		input  addr_max,
		output acc_addr,
		output dec_addr
	);

endinterface

`default_nettype wire

// ==== verilog/speed_table_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module speed_table_ram
	import ramp_pkg::*;
(
	input  logic                   clk,

	input  logic                   i_we_a,
	input  logic [RAMP_ADDR_W-1:0] i_addr_a,
	input  logic [RAMP_DATA_W-1:0] i_wdata_a,
	output logic [RAMP_DATA_W-1:0] o_rdata_a,

	input  logic                   i_we_b,
	input  logic [RAMP_ADDR_W-1:0] i_addr_b,
	input  logic [RAMP_DATA_W-1:0] i_wdata_b,
	output logic [RAMP_DATA_W-1:0] o_rdata_b
);

	logic [RAMP_DATA_W-1:0] mem [RAMP_DEPTH];

	// read-first on both ports, latency 1
	always_ff @(posedge clk) begin
		if (i_we_a)
			mem[i_addr_a] <= i_wdata_a;
		if (i_we_b)
			mem[i_addr_b] <= i_wdata_b;
		o_rdata_a <= mem[i_addr_a];
		o_rdata_b <= mem[i_addr_b];
	end

endmodule

`default_nettype wire

// ==== verilog/ramp_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module ramp_scheduler
	import ramp_pkg::*;
	import axis_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetn,

	input  logic                   i_tbl_init,
	input  logic                   i_tbl_wr_en,
	input  logic [RAMP_DATA_W-1:0] i_tbl_data,

	ramp_port_if.sched             ramp_ports [N_AXES]
);

	logic [N_SLOTS-1:0]     slot_ring;
	logic [RAMP_ADDR_W-1:0] wr_ptr;
	logic [RAMP_ADDR_W-1:0] addr_max;
	logic                   tbl_we;
	logic [RAMP_ADDR_W-1:0] addr_a;

	logic [RAMP_ADDR_W-1:0] acc_masked [N_AXES];
	logic [RAMP_ADDR_W-1:0] dec_masked [N_AXES];
	logic [RAMP_ADDR_W-1:0] acc_merge;
	logic [RAMP_ADDR_W-1:0] dec_merge;
	logic [RAMP_ADDR_W-1:0] acc_addr_q;
	logic [RAMP_ADDR_W-1:0] dec_addr_q;
	logic [RAMP_DATA_W-1:0] acc_rdata;
	logic [RAMP_DATA_W-1:0] dec_rdata;

	assign tbl_we = i_tbl_init && i_tbl_wr_en;
	assign addr_a = i_tbl_init ? wr_ptr : acc_addr_q;   // writer owns port a in init

	// table loader
	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr   <= '0;
			addr_max <= '0;
		end else if (!i_tbl_init) begin
			wr_ptr <= '0;
		end else if (i_tbl_wr_en) begin
			wr_ptr   <= wr_ptr + 1'b1;
			addr_max <= wr_ptr;
		end
	end

	// one-hot slot ring, one step per cycle
	always_ff @(posedge clk) begin
		if (!resetn)
			slot_ring <= N_SLOTS'(1);
		else
			slot_ring <= {slot_ring[N_SLOTS-2:0], slot_ring[N_SLOTS-1]};
	end

	// an axis is read two slots ahead of its own tick
	// so the ram output lands exactly on that tick
	for (genvar k = 0; k < N_AXES; k++) begin : g_axis
		assign ramp_ports[k].tick     = slot_ring[k];
		assign ramp_ports[k].acc_data = acc_rdata;
		assign ramp_ports[k].dec_data = dec_rdata;
		assign ramp_ports[k].addr_max = addr_max;

		assign acc_masked[k] = slot_ring[(k + N_SLOTS - 2) % N_SLOTS] ?
			ramp_ports[k].acc_addr : '0;
		assign dec_masked[k] = slot_ring[(k + N_SLOTS - 2) % N_SLOTS] ?
			ramp_ports[k].dec_addr : '0;
	end

	always_comb begin
		acc_merge = '0;
		dec_merge = '0;
		for (int k = 0; k < N_AXES; k++) begin
			acc_merge = acc_merge | acc_masked[k];
			dec_merge = dec_merge | dec_masked[k];
		end
	end

	always_ff @(posedge clk) begin
		acc_addr_q <= acc_merge;
		dec_addr_q <= dec_merge;
	end

	speed_table_ram u_ram (
		.clk       (clk),
		.i_we_a    (tbl_we),
		.i_addr_a  (addr_a),
		.i_wdata_a (i_tbl_data),
		.o_rdata_a (acc_rdata),
		.i_we_b    (1'b0),          // port b is read only here
		.i_addr_b  (dec_addr_q),
		.i_wdata_b ('0),
		.o_rdata_b (dec_rdata)
	);

endmodule

`default_nettype wire

// ==== verilog/axis_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_controller
	import ramp_pkg::*;
	import axis_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetn,
	ramp_port_if.axis              ramp,

	input  logic                   i_cmd_req,
	input  axis_cmd_e              i_cmd,
	output logic                   o_cmd_ack,

	input  logic [STEP_W-1:0]      i_step,
	input  logic [RAMP_DATA_W-1:0] i_speed,
	input  logic                   i_dir,
	input  logic [STEP_W-1:0]      i_stroke,
	input  logic                   i_zpd,      // home sensor

	output logic                   o_step,
	output logic                   o_dir,
	output logic                   o_busy,
	output logic [STEP_W-1:0]      o_pos,
	output logic [RAMP_DATA_W-1:0] o_rt_period,
	output logic                   o_home,
	output logic                   o_limit
);

	axis_state_e            state;
	logic                   stop_pend;
	logic                   primed;     // table addresses for step 0 issued
	logic [STEP_W-1:0]      total;
	logic [STEP_W-1:0]      n_done;
	logic [RAMP_DATA_W-1:0] tick_cnt;
	logic [RAMP_DATA_W-1:0] period;
	logic [STEP_W-1:0]      n_next;
	logic [STEP_W-1:0]      rem_m1;
	logic                   moving;
	logic                   accept;
	logic                   end_now;
	logic                   due;
	logic                   at_stroke;
	logic                   adv;
	logic                   fire;

	function automatic logic [RAMP_ADDR_W-1:0] clamp_addr(input logic [STEP_W-1:0] v,
		input logic [RAMP_ADDR_W-1:0] amax);
		if (v >= STEP_W'(amax))
			return amax;
		return v[RAMP_ADDR_W-1:0];
	endfunction

	// largest of accel entry, decel entry and the commanded floor
	always_comb begin
		period = i_speed;
		if (ramp.acc_data > period)
			period = ramp.acc_data;
		if (ramp.dec_data > period)
			period = ramp.dec_data;
	end

	assign moving    = (state == ST_RUN) || (state == ST_HOMING);
	assign accept    = i_cmd_req && !o_cmd_ack && (i_cmd == CMD_STOP || state == ST_IDLE);
	assign n_next    = primed ? n_done + 1'b1 : n_done;
	assign rem_m1    = total - n_next - 1'b1;
	assign due       = primed && (tick_cnt + 1'b1 >= period);
	assign at_stroke = o_dir && (o_pos >= i_stroke);
	assign end_now   = stop_pend || (state == ST_HOMING && i_zpd) ||
		(state == ST_RUN && n_done == total);

	// new addresses on the priming tick and on every step
	assign adv  = ramp.tick && moving && !end_now && (!primed || (due && !at_stroke));
	assign fire = adv && primed;

	assign o_step = fire;
	assign o_busy = moving;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state       <= ST_IDLE;
			o_cmd_ack   <= 1'b0;
			stop_pend   <= 1'b0;
			primed      <= 1'b0;
			o_dir       <= 1'b0;
			o_pos       <= '0;
			o_home      <= 1'b0;
			o_limit     <= 1'b0;
			o_rt_period <= '0;
		end else begin
			if (accept)
				o_cmd_ack <= 1'b1;
			else if (!i_cmd_req)
				o_cmd_ack <= 1'b0;     // drop one cycle after req

			if (accept) begin
				o_home  <= 1'b0;
				o_limit <= 1'b0;
				if (i_cmd == CMD_STOP) begin
					if (moving)
						stop_pend <= 1'b1;
					else
						state <= ST_ACK_WAIT;
				end else begin
					state     <= (i_cmd == CMD_HOME) ? ST_HOMING : ST_RUN;
					o_dir     <= (i_cmd == CMD_HOME) ? 1'b0 : i_dir;
					total     <= i_step;
					n_done    <= '0;
					primed    <= 1'b0;
					stop_pend <= 1'b0;
				end
			end else if (state == ST_ACK_WAIT && !o_cmd_ack) begin
				state <= ST_IDLE;
			end

			if (ramp.tick && moving) begin
				if (end_now) begin
					state     <= ST_ACK_WAIT;
					stop_pend <= 1'b0;
					if (state == ST_HOMING && i_zpd) begin
						o_pos  <= '0;
						o_home <= 1'b1;
					end
				end else if (primed) begin
					o_rt_period <= period;
					if (!due) begin
						tick_cnt <= tick_cnt + 1'b1;
					end else if (at_stroke) begin
						state   <= ST_ACK_WAIT;    // would pass the stroke
						o_limit <= 1'b1;
					end
				end
			end

			if (adv) begin
				primed   <= 1'b1;
				tick_cnt <= '0;
				n_done   <= n_next;
			end
			if (fire)
				o_pos <= o_dir ? o_pos + 1'b1 : o_pos - 1'b1;
		end
	end

	// held until the next own tick, the ram read lands in between
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ramp.acc_addr <= '0;
			ramp.dec_addr <= '0;
		end else if (adv) begin
			ramp.acc_addr <= clamp_addr(n_next, ramp.addr_max);
			ramp.dec_addr <= (state == ST_HOMING) ? ramp.addr_max :
				clamp_addr(rem_m1, ramp.addr_max);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/stepper_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stepper_top
	import ramp_pkg::*;
	import axis_pkg::*;
(
	input  logic                                clk,
	input  logic                                resetn,

	input  logic                                i_tbl_init,
	input  logic                                i_tbl_wr_en,
	input  logic [RAMP_DATA_W-1:0]              i_tbl_data,

	input  logic [N_AXES-1:0]                   i_cmd_req,
	input  logic [N_AXES-1:0][CMD_W-1:0]        i_cmd,
	output logic [N_AXES-1:0]                   o_cmd_ack,
	input  logic [N_AXES-1:0][STEP_W-1:0]       i_step,
	input  logic [N_AXES-1:0][RAMP_DATA_W-1:0]  i_speed,
	input  logic [N_AXES-1:0]                   i_dir,
	input  logic [N_AXES-1:0][STEP_W-1:0]       i_stroke,
	input  logic [N_AXES-1:0]                   i_zpd,

	output logic [N_AXES-1:0]                   o_step,
	output logic [N_AXES-1:0]                   o_dir,
	output logic [N_AXES-1:0]                   o_busy,
	output logic [N_AXES-1:0][STEP_W-1:0]       o_pos,
	output logic [N_AXES-1:0][RAMP_DATA_W-1:0]  o_rt_period,
	output logic [N_AXES-1:0]                   o_home,
	output logic [N_AXES-1:0]                   o_limit
);

	ramp_port_if u_ramp_port [N_AXES] ();    // one table port per axis

	ramp_scheduler u_sched (
		.clk         (clk),
		.resetn      (resetn),
		.i_tbl_init  (i_tbl_init),
		.i_tbl_wr_en (i_tbl_wr_en),
		.i_tbl_data  (i_tbl_data),
		.ramp_ports  (u_ramp_port)
	);

	for (genvar k = 0; k < N_AXES; k++) begin : g_axis
		axis_controller u_axis (
			.clk         (clk),
			.resetn      (resetn),
			.ramp        (u_ramp_port[k]),
			.i_cmd_req   (i_cmd_req[k]),
			.i_cmd       (axis_cmd_e'(i_cmd[k])),
			.o_cmd_ack   (o_cmd_ack[k]),
			.i_step      (i_step[k]),
			.i_speed     (i_speed[k]),
			.i_dir       (i_dir[k]),
			.i_stroke    (i_stroke[k]),
			.i_zpd       (i_zpd[k]),
			.o_step      (o_step[k]),
			.o_dir       (o_dir[k]),
			.o_busy      (o_busy[k]),
			.o_pos       (o_pos[k]),
			.o_rt_period (o_rt_period[k]),
			.o_home      (o_home[k]),
			.o_limit     (o_limit[k])
		);
	end

endmodule

`default_nettype wire

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk,
	output logic resetn
);

	localparam time HALF_PERIOD = 20ns;    // 40 ns clock

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		resetn = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

`default_nettype wire

// ==== dv/tb_stepper_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_stepper_top
	import ramp_pkg::*;
	import axis_pkg::*;
();

	localparam int N_TBL  = 16;
	localparam int AMAX   = N_TBL - 1;    // last address written
	localparam int N_ROWS = 9;

	logic                               clk;
	logic                               resetn;
	logic                               i_tbl_init;
	logic                               i_tbl_wr_en;
	logic [RAMP_DATA_W-1:0]             i_tbl_data;
	logic [N_AXES-1:0]                  i_cmd_req;
	logic [N_AXES-1:0][CMD_W-1:0]       i_cmd;
	logic [N_AXES-1:0]                  o_cmd_ack;
	logic [N_AXES-1:0][STEP_W-1:0]      i_step;
	logic [N_AXES-1:0][RAMP_DATA_W-1:0] i_speed;
	logic [N_AXES-1:0]                  i_dir;
	logic [N_AXES-1:0][STEP_W-1:0]      i_stroke;
	logic [N_AXES-1:0]                  i_zpd;
	logic [N_AXES-1:0]                  o_step;
	logic [N_AXES-1:0]                  o_dir;
	logic [N_AXES-1:0]                  o_busy;
	logic [N_AXES-1:0][STEP_W-1:0]      o_pos;
	logic [N_AXES-1:0][RAMP_DATA_W-1:0] o_rt_period;
	logic [N_AXES-1:0]                  o_home;
	logic [N_AXES-1:0]                  o_limit;

	int tbl_mem [N_TBL] = '{20, 16, 13, 11, 9, 8, 7, 6, 5, 5, 4, 4, 3, 3, 2, 2};

	// command table, expected values filled in by build_rows
	int r_ax [N_ROWS];
	int r_op [N_ROWS];
	int r_step [N_ROWS];
	int r_speed [N_ROWS];
	int r_dir [N_ROWS];
	int r_stroke [N_ROWS];
	int r_event [N_ROWS];   // pulses before stop or home sensor
	int e_pulses [N_ROWS];
	int e_pos [N_ROWS];
	int e_home [N_ROWS];
	int e_limit [N_ROWS];

	// per-axis reference model
	int cnt [N_AXES];
	int tot [N_AXES];
	int spd [N_AXES];
	int chk [N_AXES];
	int edir [N_AXES];
	int done [N_AXES];
	int last_cyc [N_AXES];
	int rt_exp [N_AXES];
	bit rt_pend [N_AXES];   // period readback due one cycle after a step
	logic [STEP_W-1:0] mpos [N_AXES];

	int cyc;
	int err_cnt;
	int chk_cnt;
	bit built;
	logic [31:0] rng;

	clk_gen u_clk_gen (
		.clk    (clk),
		.resetn (resetn)
	);

	stepper_top u_stepper_top (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic int rand_range(int lo, int hi);
		rng = xorshift(rng);
		return lo + int'(rng % (hi - lo + 1));
	endfunction

	// largest of accel entry, decel entry and speed floor
	function automatic int period_of(int n, int total, int speed);
		int a;
		int d;
		int p;
		a = (n < AMAX) ? n : AMAX;
		d = (total - n - 1 < AMAX) ? total - n - 1 : AMAX;
		p = tbl_mem[a];
		if (tbl_mem[d] > p)
			p = tbl_mem[d];
		if (speed > p)
			p = speed;
		return p;
	endfunction

	task automatic check_value(string what, int got, int exp);
		chk_cnt++;
		assert (got == exp) else begin
			err_cnt++;
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic set_row(int i, int ax, int op, int step, int speed, int dir,
		int stroke, int ev);
		r_ax[i] = ax;
		r_op[i] = op;
		r_step[i] = step;
		r_speed[i] = speed;
		r_dir[i] = dir;
		r_stroke[i] = stroke;
		r_event[i] = ev;
		e_home[i] = (op == CMD_HOME);
		e_limit[i] = 0;
		e_pulses[i] = (ev > 0) ? ev : step;
		if (op == CMD_MOVE && dir == 1 && ev == 0 && int'(mpos[ax]) + step > stroke) begin
			e_pulses[i] = stroke - int'(mpos[ax]);   // stops at the stroke
			e_limit[i] = 1;
		end
		if (op == CMD_HOME)
			mpos[ax] = '0;
		else if (dir == 1)
			mpos[ax] = mpos[ax] + STEP_W'(e_pulses[i]);
		else
			mpos[ax] = mpos[ax] - STEP_W'(e_pulses[i]);
		e_pos[i] = int'(mpos[ax]);
	endtask

	task automatic build_rows();
		set_row(0, 0, CMD_MOVE, 5, 1, 1, 1000, 0);
		set_row(1, 0, CMD_MOVE, rand_range(20, 40), 3, 1, 1000, 0);
		set_row(2, 1, CMD_MOVE, 12, 6, 0, 1000, 0);
		set_row(3, 0, CMD_MOVE, 200, 1, 1, 1000, rand_range(4, 10));
		set_row(4, 1, CMD_HOME, 0, 2, 0, 1000, rand_range(3, 8));
		set_row(5, 1, CMD_MOVE, 4, 2, 1, 1000, 0);
		set_row(6, 0, CMD_MOVE, 50, 1, 1, int'(mpos[0]) + 9, 0);
		set_row(7, 0, CMD_MOVE, 10, 4, 0, 1000, 0);   // 7 and 8 run together
		set_row(8, 1, CMD_MOVE, rand_range(6, 14), 2, 1, 1000, 0);
	endtask

	task automatic issue_cmd(int ax, int op, int step, int speed, int dir, int stroke);
		@(negedge clk);
		i_cmd[ax] = CMD_W'(op);
		i_step[ax] = STEP_W'(step);
		i_speed[ax] = RAMP_DATA_W'(speed);
		i_dir[ax] = dir[0];
		i_stroke[ax] = STEP_W'(stroke);
		i_cmd_req[ax] = 1'b1;
		while (!o_cmd_ack[ax])
			@(negedge clk);
		i_cmd_req[ax] = 1'b0;
		while (o_cmd_ack[ax])
			@(negedge clk);
	endtask

	task automatic run_row(int i);
		int ax;
		ax = r_ax[i];
		done[ax] = 0;
		cnt[ax] = 0;
		tot[ax] = r_step[i];
		spd[ax] = r_speed[i];
		chk[ax] = (r_op[i] == CMD_MOVE);
		edir[ax] = (r_op[i] == CMD_HOME) ? 0 : r_dir[i];
		issue_cmd(ax, r_op[i], r_step[i], r_speed[i], r_dir[i], r_stroke[i]);
		if (r_event[i] > 0) begin
			while (cnt[ax] < r_event[i])
				@(negedge clk);
			if (r_op[i] == CMD_HOME)
				i_zpd[ax] = 1'b1;
			else
				issue_cmd(ax, CMD_STOP, r_step[i], r_speed[i], r_dir[i], r_stroke[i]);
		end
		while (o_busy[ax])
			@(negedge clk);
		i_zpd[ax] = 1'b0;
		check_value($sformatf("row %0d pulses", i), cnt[ax], e_pulses[i]);
		check_value($sformatf("row %0d o_pos", i), int'(o_pos[ax]), e_pos[i]);
		check_value($sformatf("row %0d o_home", i), int'(o_home[ax]), e_home[i]);
		check_value($sformatf("row %0d o_limit", i), int'(o_limit[ax]), e_limit[i]);
		done[ax] = 1;
	endtask

	// second move on axis 0 while row 7 still runs
	task automatic busy_move_check();
		while (!o_busy[0] || cnt[0] < 2)
			@(negedge clk);
		i_cmd[0] = CMD_W'(CMD_MOVE);
		i_step[0] = STEP_W'(3);
		i_speed[0] = RAMP_DATA_W'(2);
		i_dir[0] = 1'b1;
		i_cmd_req[0] = 1'b1;
		while (!o_cmd_ack[0])
			@(negedge clk);
		chk_cnt++;
		assert (done[0] == 1) else begin
			err_cnt++;
			$display("axis 0 acknowledged a move while still busy at %0t", $time);
		end
		cnt[0] = 0;
		tot[0] = 3;
		spd[0] = 2;
		edir[0] = 1;
		i_cmd_req[0] = 1'b0;
		while (o_cmd_ack[0] || o_busy[0])
			@(negedge clk);
		check_value("queued move pulses", cnt[0], 3);
		check_value("queued move o_pos", int'(o_pos[0]), e_pos[7] + 3);
	endtask

	// pulse counter and gap model
	always @(posedge clk) begin
		int exp_gap;
		cyc = cyc + 1;
		for (int a = 0; a < N_AXES; a++) begin
			if (rt_pend[a]) begin
				check_value($sformatf("axis %0d o_rt_period", a),
					int'(o_rt_period[a]), rt_exp[a]);
				rt_pend[a] = 1'b0;
			end
			if (o_step[a]) begin
				check_value($sformatf("axis %0d o_dir", a), int'(o_dir[a]), edir[a]);
				if (chk[a]) begin
					rt_exp[a] = period_of(cnt[a], tot[a], spd[a]);
					rt_pend[a] = 1'b1;
					if (cnt[a] > 0) begin
						exp_gap = rt_exp[a] * N_SLOTS;
						check_value($sformatf("axis %0d gap before step %0d", a, cnt[a]),
							cyc - last_cyc[a], exp_gap);
					end
				end
				cnt[a] = cnt[a] + 1;
				last_cyc[a] = cyc;
			end
		end
	end

	initial begin
		longint lim;
		int max_p;
		wait (built);
		max_p = 0;
		lim = 3;
		for (int i = 0; i < N_TBL; i++)
			if (tbl_mem[i] > max_p)
				max_p = tbl_mem[i];
		for (int i = 0; i < N_ROWS; i++)
			lim += r_step[i];
		lim = lim * max_p * N_SLOTS * 2 + 1000;
		#(lim * 40);
		$display("watchdog expired after %0d cycles, the DUT stopped responding", lim);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		i_tbl_init = 1'b0;
		i_tbl_wr_en = 1'b0;
		i_tbl_data = '0;
		i_cmd_req = '0;
		i_cmd = '0;
		i_step = '0;
		i_speed = '0;
		i_dir = '0;
		i_stroke = '0;
		i_zpd = '0;
		cyc = 0;
		err_cnt = 0;
		chk_cnt = 0;
		rng = 32'h465c7e63;
		for (int a = 0; a < N_AXES; a++) begin
			cnt[a] = 0;
			chk[a] = 0;
			edir[a] = 0;
			rt_pend[a] = 1'b0;
			mpos[a] = '0;
		end
		build_rows();
		built = 1'b1;

		@(posedge resetn);
		@(negedge clk);
		for (int a = 0; a < N_AXES; a++) begin
			check_value("reset o_step", int'(o_step[a]), 0);
			check_value("reset o_busy", int'(o_busy[a]), 0);
			check_value("reset o_cmd_ack", int'(o_cmd_ack[a]), 0);
			check_value("reset o_home", int'(o_home[a]), 0);
			check_value("reset o_limit", int'(o_limit[a]), 0);
			check_value("reset o_pos", int'(o_pos[a]), 0);
		end

		i_tbl_init = 1'b1;
		for (int i = 0; i < N_TBL; i++) begin
			@(negedge clk);
			i_tbl_wr_en = 1'b1;
			i_tbl_data = RAMP_DATA_W'(tbl_mem[i]);
		end
		@(negedge clk);
		i_tbl_wr_en = 1'b0;
		i_tbl_init = 1'b0;

		for (int i = 0; i < 7; i++)
			run_row(i);
		fork
			run_row(7);
			run_row(8);
			busy_move_check();
		join

		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/ramp_pkg.sv
verilog/axis_pkg.sv
verilog/ramp_port_if.sv
verilog/speed_table_ram.sv
verilog/ramp_scheduler.sv
verilog/axis_controller.sv
verilog/stepper_top.sv
dv/clk_gen.sv
dv/tb_stepper_top.sv

// ==== Bender.yml ====
package:
  name: stepper_top

sources:
  - verilog/ramp_pkg.sv
  - verilog/axis_pkg.sv
  - verilog/ramp_port_if.sv
  - verilog/speed_table_ram.sv
  - verilog/ramp_scheduler.sv
  - verilog/axis_controller.sv
  - verilog/stepper_top.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/tb_stepper_top.sv
